//--- design/mmc_pkg.sv
// Package with MMC command codes, SPI operations, card tokens and request/response structs.
package mmc_pkg;

   // Host request codes; code 3 is ignored.
   typedef enum logic [1:0]
   {
      BD_RESET = 2'd0,
      BD_READ  = 2'd1,
      BD_WRITE = 2'd2
   } bd_cmd_e;

   typedef enum logic [2:0]
   {
      SPI_NONE    = 3'd0,
      SPI_INIT    = 3'd1,
      SPI_FRAME   = 3'd2,
      SPI_READ    = 3'd3,
      SPI_WRITE   = 3'd4,
      SPI_RELEASE = 3'd5
   } spi_op_e;

   typedef struct packed
   {
      spi_op_e     op;
      logic [47:0] frame;
      logic [7:0]  wbyte;
      logic        fast;
   } spi_req_t;

   typedef struct packed
   {
      logic       done;
      logic [7:0] data;
   } spi_rsp_t;

   // Card tokens and R1 codes.
   localparam logic [7:0] TOKEN_START   = 8'hfe;
   localparam logic [7:0] R1_IDLE       = 8'h01;
   localparam logic [7:0] R1_READY      = 8'h00;
   localparam logic [7:0] BUS_FLOAT     = 8'hff;
   localparam logic [2:0] DATA_ACCEPTED = 3'b010;

   // Fixed frames, CRC included for CMD0.
   localparam logic [47:0] CMD_GO_IDLE_FRAME = 48'h40_0000_0000_95;
   localparam logic [47:0] CMD_SEND_OP_FRAME = 48'h41_0000_0000_01;
   localparam logic [47:0] DUMMY_FRAME       = 48'hff_ffff_ffff_ff;

   localparam logic [7:0] CMD_SET_BLOCKLEN = 8'h50;
   localparam logic [7:0] CMD_READ_SINGLE  = 8'h51;
   localparam logic [7:0] CMD_WRITE_SINGLE = 8'h58;
   localparam logic [7:0] FRAME_STOP       = 8'h01;

endpackage

//--- design/spi_byte_engine.sv
// SPI engine for MMC bring-up clocks, command frames, byte reads and writes, and CS release.
`timescale 1ns/1ps

module spi_byte_engine
   import mmc_pkg::*;
#(
   parameter int SLOW_DIV = 64,
   parameter int FAST_DIV = 2
)
(
   input  logic     clk,
   input  logic     reset,
   input  spi_req_t req,
   output spi_rsp_t rsp,
   output logic     mmc_cs,
   output logic     mmc_sclk,
   output logic     mmc_do,
   input  logic     mmc_di
);

   localparam int DIV_W = $clog2(SLOW_DIV + FAST_DIV + 1);

   logic             busy;
   logic             done_r;
   logic [6:0]       bits_left;
   logic [47:0]      tx_sr;
   logic [7:0]       rx_sr;
   logic [DIV_W-1:0] div_cnt;
   logic [DIV_W-1:0] reload;
   logic             start;
   logic             tick;

   assign reload = req.fast ? DIV_W'(FAST_DIV - 1) : DIV_W'(SLOW_DIV - 1);
   assign start  = !busy && done_r && (req.op != SPI_NONE);
   assign tick   = busy && (div_cnt == '0);

   always_ff @(posedge clk)
   begin
      if (reset)
      begin
         busy      <= 1'b0;
         done_r    <= 1'b1;
         mmc_cs    <= 1'b1;
         mmc_sclk  <= 1'b0;
         bits_left <= '0;
         div_cnt   <= '0;
         tx_sr     <= '1;
      end
      else if (start)
      begin
         busy    <= 1'b1;
         done_r  <= 1'b0;
         div_cnt <= reload;
         case (req.op)
            SPI_INIT:
            begin
               // Card wants 74+ clocks with CS high.
               mmc_cs    <= 1'b1;
               bits_left <= 7'd80;
               tx_sr     <= '1;
            end
            SPI_FRAME:
            begin
               mmc_cs    <= 1'b0;
               bits_left <= 7'd48;
               tx_sr     <= req.frame;
            end
            SPI_WRITE:
            begin
               mmc_cs    <= 1'b0;
               bits_left <= 7'd8;
               tx_sr     <= {req.wbyte, 40'hff_ffff_ffff};
            end
            SPI_RELEASE:
            begin
               mmc_cs    <= 1'b1;
               bits_left <= 7'd8;
               tx_sr     <= '1;
            end
            default:
            begin
               mmc_cs    <= 1'b0;
               bits_left <= 7'd8;
               tx_sr     <= '1;
            end
         endcase
      end
      else if (busy)
      begin
         if (div_cnt != '0)
            div_cnt <= div_cnt - 1'b1;
         else
         begin
            div_cnt  <= reload;
            mmc_sclk <= ~mmc_sclk;
            // Falling edge moves to the next bit.
            if (mmc_sclk)
            begin
               tx_sr     <= {tx_sr[46:0], 1'b1};
               bits_left <= bits_left - 1'b1;
               if (bits_left == 7'd1)
               begin
                  busy   <= 1'b0;
                  done_r <= 1'b1;
               end
            end
         end
      end
   end

   // Card output sampled on the rising edge.
   always_ff @(posedge clk)
   begin
      if (tick && !mmc_sclk)
         rx_sr <= {rx_sr[6:0], mmc_di};
   end

   assign mmc_do   = tx_sr[47];
   assign rsp.done = done_r;
   assign rsp.data = rx_sr;

endmodule

//--- design/mmc_cmd_sequencer.sv
// MMC command sequencer FSM for card bring-up, block read, block write and errors.
`timescale 1ns/1ps

module mmc_cmd_sequencer
   import mmc_pkg::*;
#(
   parameter int BLOCK_WORDS = 256
)
(
   input  logic        clk,
   input  logic        reset,
   input  logic        bd_start,
   input  bd_cmd_e     bd_cmd,
   input  logic        bd_rd,
   input  logic        bd_wr,
   output logic        bd_bsy,
   output logic        bd_rdy,
   output logic        bd_iordy,
   output logic        bd_err,
   output spi_req_t    spi_req,
   input  spi_rsp_t    spi_rsp,
   output logic        clear_words,
   output logic        step_word,
   output logic        step_block,
   output logic        clear_blocks,
   input  logic        last_word,
   input  logic        last_block,
   input  logic [31:0] block_byte_addr,
   output logic        take_host_word,
   output logic        capture_low,
   output logic        capture_high,
   input  logic [7:0]  tx_low,
   input  logic [7:0]  tx_high
);

   typedef enum logic [5:0]
   {
      S_IDLE, S_PRE, S_CMD0, S_R0, S_REL0, S_CMD1, S_R1, S_RETRY1, S_REL1,
      S_CMD16, S_R16, S_REL16, S_UP, S_DUMMY, S_XCMD, S_XR, S_TOKEN,
      S_RLO, S_RHI, S_RWORD, S_RCRC0, S_RCRC1, S_WTOK, S_WWAIT, S_WLO, S_WHI,
      S_WACK, S_WCRC0, S_WCRC1, S_WRSP, S_WBUSY, S_XREL, S_NEXT, S_EREL, S_DONE
   } state_e;

   localparam logic [31:0] BLOCK_BYTES = 32'(BLOCK_WORDS * 2);

   state_e      state;
   state_e      state_next;
   logic        phase;
   logic        fin;
   spi_op_e     op;
   logic [47:0] frame;
   logic [7:0]  wbyte;
   logic [7:0]  rx;
   logic        start_q;
   bd_cmd_e     cmd_hold;
   logic        inited;
   logic        set_inited;
   logic        fast;
   logic        set_fast;
   logic        clr_fast;
   logic        err;
   logic        set_err;
   logic        clear_err;

   // Phase 0 issues the op, phase 1 waits for done.
   assign fin = phase && spi_rsp.done;
   assign rx  = spi_rsp.data;

   always_ff @(posedge clk)
   begin
      if (reset)
      begin
         state    <= S_IDLE;
         phase    <= 1'b0;
         start_q  <= 1'b0;
         cmd_hold <= BD_RESET;
         inited   <= 1'b0;
         fast     <= 1'b0;
         err      <= 1'b0;
      end
      else
      begin
         state   <= state_next;
         start_q <= bd_start;
         if (bd_start && state == S_IDLE)
            cmd_hold <= bd_cmd;
         if (op != SPI_NONE && !phase && !spi_rsp.done)
            phase <= 1'b1;
         else if (fin)
            phase <= 1'b0;
         if (set_inited)
            inited <= 1'b1;
         if (set_fast)
            fast <= 1'b1;
         else if (clr_fast)
            fast <= 1'b0;
         if (clear_err)
            err <= 1'b0;
         else if (set_err)
            err <= 1'b1;
      end
   end

   always_comb
   begin
      state_next     = state;
      op             = SPI_NONE;
      frame          = DUMMY_FRAME;
      wbyte          = 8'h00;
      set_inited     = 1'b0;
      set_fast       = 1'b0;
      clr_fast       = 1'b0;
      set_err        = 1'b0;
      clear_err      = 1'b0;
      clear_words    = 1'b0;
      step_word      = 1'b0;
      step_block     = 1'b0;
      clear_blocks   = 1'b0;
      take_host_word = 1'b0;
      capture_low    = 1'b0;
      capture_high   = 1'b0;

      case (state)
         S_IDLE:
            if (start_q && cmd_hold != 2'd3)
               state_next = (cmd_hold == BD_RESET || !inited) ? S_PRE : S_DUMMY;
         S_PRE:
         begin
            clr_fast = 1'b1;
            op = SPI_INIT;
            if (fin) state_next = S_CMD0;
         end
         S_CMD0:
         begin
            op = SPI_FRAME;
            frame = CMD_GO_IDLE_FRAME;
            if (fin) state_next = S_R0;
         end
         S_R0:
         begin
            op = SPI_READ;
            if (fin)
            begin
               if (rx == R1_IDLE)
                  state_next = S_REL0;
               else if (!rx[7])
                  state_next = S_PRE;
            end
         end
         S_REL0:
         begin
            op = SPI_RELEASE;
            if (fin) state_next = S_CMD1;
         end
         S_CMD1:
         begin
            op = SPI_FRAME;
            frame = CMD_SEND_OP_FRAME;
            if (fin) state_next = S_R1;
         end
         S_R1:
         begin
            op = SPI_READ;
            if (fin && rx == R1_READY)
               state_next = S_REL1;
            else if (fin && rx != BUS_FLOAT)
               state_next = S_RETRY1;
         end
         S_RETRY1:
         begin
            op = SPI_RELEASE;
            if (fin) state_next = S_CMD1;
         end
         S_REL1:
         begin
            op = SPI_RELEASE;
            set_fast = fin;
            if (fin) state_next = S_CMD16;
         end
         S_CMD16:
         begin
            op = SPI_FRAME;
            frame = {CMD_SET_BLOCKLEN, BLOCK_BYTES, FRAME_STOP};
            if (fin) state_next = S_R16;
         end
         S_R16:
         begin
            op = SPI_READ;
            if (fin && rx == R1_READY)
               state_next = S_REL16;
            else if (fin && rx != BUS_FLOAT)
            begin
               set_err = 1'b1;
               state_next = S_EREL;
            end
         end
         S_REL16:
         begin
            op = SPI_RELEASE;
            if (fin) state_next = S_UP;
         end
         S_UP:
         begin
            set_inited = 1'b1;
            state_next = (cmd_hold == BD_RESET) ? S_DONE : S_DUMMY;
         end
         S_DUMMY:
         begin
            clear_words = 1'b1;
            op = SPI_FRAME;
            if (fin) state_next = S_XCMD;
         end
         S_XCMD:
         begin
            op = SPI_FRAME;
            frame = {(cmd_hold == BD_WRITE) ? CMD_WRITE_SINGLE : CMD_READ_SINGLE,
                     block_byte_addr, FRAME_STOP};
            if (fin) state_next = S_XR;
         end
         S_XR:
         begin
            op = SPI_READ;
            if (fin && rx == R1_READY)
               state_next = (cmd_hold == BD_WRITE) ? S_WTOK : S_TOKEN;
            else if (fin && rx != BUS_FLOAT)
            begin
               set_err = 1'b1;
               state_next = S_EREL;
            end
         end
         S_TOKEN:
         begin
            op = SPI_READ;
            if (fin && rx == TOKEN_START) state_next = S_RLO;
         end
         S_RLO:
         begin
            op = SPI_READ;
            capture_low = fin;
            if (fin) state_next = S_RHI;
         end
         S_RHI:
         begin
            op = SPI_READ;
            capture_high = fin;
            if (fin) state_next = S_RWORD;
         end
         S_RWORD:
            if (bd_rd)
            begin
               step_word = 1'b1;
               state_next = last_word ? S_RCRC0 : S_RLO;
            end
         S_RCRC0:
         begin
            op = SPI_READ;
            if (fin) state_next = S_RCRC1;
         end
         S_RCRC1:
         begin
            op = SPI_READ;
            if (fin) state_next = S_XREL;
         end
         S_WTOK:
         begin
            op = SPI_WRITE;
            wbyte = TOKEN_START;
            if (fin) state_next = S_WWAIT;
         end
         S_WWAIT:
            if (bd_wr)
            begin
               take_host_word = 1'b1;
               state_next = S_WLO;
            end
         S_WLO:
         begin
            op = SPI_WRITE;
            wbyte = tx_low;
            if (fin) state_next = S_WHI;
         end
         S_WHI:
         begin
            op = SPI_WRITE;
            wbyte = tx_high;
            if (fin) state_next = S_WACK;
         end
         S_WACK:
            if (!bd_wr)
            begin
               step_word = 1'b1;
               state_next = last_word ? S_WCRC0 : S_WWAIT;
            end
         S_WCRC0:
         begin
            op = SPI_WRITE;
            if (fin) state_next = S_WCRC1;
         end
         S_WCRC1:
         begin
            op = SPI_WRITE;
            if (fin) state_next = S_WRSP;
         end
         S_WRSP:
         begin
            op = SPI_READ;
            if (fin && rx[3:1] == DATA_ACCEPTED)
               state_next = S_WBUSY;
            else if (fin && rx != BUS_FLOAT)
            begin
               set_err = 1'b1;
               state_next = S_EREL;
            end
         end
         S_WBUSY:
         begin
            // Card holds the line low while programming.
            op = SPI_READ;
            if (fin && rx != 8'h00) state_next = S_XREL;
         end
         S_XREL:
         begin
            op = SPI_RELEASE;
            if (fin) state_next = S_NEXT;
         end
         S_NEXT:
         begin
            step_block = 1'b1;
            state_next = last_block ? S_DONE : S_DUMMY;
         end
         S_EREL:
         begin
            op = SPI_RELEASE;
            if (fin) state_next = S_DONE;
         end
         S_DONE:
         begin
            clear_err = 1'b1;
            clear_blocks = 1'b1;
            state_next = S_IDLE;
         end
         default:
            state_next = S_IDLE;
      endcase
   end

   assign spi_req.op    = phase ? SPI_NONE : op;
   assign spi_req.frame = frame;
   assign spi_req.wbyte = wbyte;
   assign spi_req.fast  = fast;

   assign bd_bsy   = (state != S_IDLE);
   assign bd_err   = err && (state == S_DONE);
   assign bd_iordy = (state == S_RWORD) || (state == S_WACK);
   assign bd_rdy   = (state == S_IDLE) || (state == S_RWORD) ||
                     (state == S_WWAIT) || (state == S_WACK);

endmodule

//--- design/transfer_tracker.sv
// Word counter, block counter and byte address of the current block.
`timescale 1ns/1ps

module transfer_tracker #(
   parameter int BLOCK_WORDS    = 256,
   parameter int BLOCKS_PER_REQ = 2
)
(
   input  logic        clk,
   input  logic        reset,
   input  logic        bd_start,
   input  logic [23:0] bd_addr,
   input  logic        clear_words,
   input  logic        step_word,
   input  logic        step_block,
   input  logic        clear_blocks,
   output logic        last_word,
   output logic        last_block,
   output logic [31:0] block_byte_addr
);

   localparam int WC_W = $clog2(BLOCK_WORDS + 1);
   localparam int BC_W = $clog2(BLOCKS_PER_REQ + 1);
   localparam int SHIFT = $clog2(BLOCK_WORDS * 2);

   logic [WC_W-1:0] wc;
   logic [BC_W-1:0] bc;

   always_ff @(posedge clk)
   begin
      if (reset)
      begin
         wc <= '0;
         bc <= '0;
         block_byte_addr <= '0;
      end
      else
      begin
         if (clear_words)
            wc <= '0;
         else if (step_word)
            wc <= wc + 1'b1;
         if (clear_blocks)
            bc <= '0;
         else if (step_block)
            bc <= bc + 1'b1;
         if (bd_start)
            block_byte_addr <= 32'(bd_addr) << SHIFT;
         else if (step_block)
            block_byte_addr <= block_byte_addr + 32'(BLOCK_WORDS * 2);
      end
   end

   assign last_word  = (wc == WC_W'(BLOCK_WORDS - 1));
   assign last_block = (bc == BC_W'(BLOCKS_PER_REQ - 1));

endmodule

//--- design/word_staging.sv
// Holding registers for host write words and assembled read words.
`timescale 1ns/1ps

module word_staging (
   input  logic        clk,
   input  logic        reset,
   input  logic [15:0] bd_data_in,
   input  logic        take_host_word,
   input  logic        capture_low,
   input  logic        capture_high,
   input  logic [7:0]  rx_byte,
   output logic [7:0]  tx_low,
   output logic [7:0]  tx_high,
   output logic [15:0] bd_data_out
);

   logic [15:0] tx_hold;

   always_ff @(posedge clk)
   begin
      if (take_host_word)
         tx_hold <= bd_data_in;
   end

   // Read words arrive low byte first.
   always_ff @(posedge clk)
   begin
      if (reset)
         bd_data_out <= '0;
      else if (capture_low)
         bd_data_out[7:0] <= rx_byte;
      else if (capture_high)
         bd_data_out[15:8] <= rx_byte;
   end

   assign tx_low  = tx_hold[7:0];
   assign tx_high = tx_hold[15:8];

endmodule

//--- design/mmc_block_dev.sv
// Top level of the MMC block device controller with host and card ports.
`timescale 1ns/1ps

module mmc_block_dev
   import mmc_pkg::*;
#(
   parameter int BLOCK_WORDS    = 256,
   parameter int BLOCKS_PER_REQ = 2,
   parameter int SLOW_DIV       = 64,
   parameter int FAST_DIV       = 2
)
(
   input  logic        clk,
   input  logic        reset,
   input  bd_cmd_e     bd_cmd,
   input  logic        bd_start,
   output logic        bd_bsy,
   output logic        bd_rdy,
   output logic        bd_err,
   input  logic [23:0] bd_addr,
   input  logic [15:0] bd_data_in,
   output logic [15:0] bd_data_out,
   input  logic        bd_rd,
   input  logic        bd_wr,
   output logic        bd_iordy,
   output logic        mmc_cs,
   input  logic        mmc_di,
   output logic        mmc_do,
   output logic        mmc_sclk
);

   spi_req_t    spi_req;
   spi_rsp_t    spi_rsp;
   logic        clear_words;
   logic        step_word;
   logic        step_block;
   logic        clear_blocks;
   logic        last_word;
   logic        last_block;
   logic [31:0] block_byte_addr;
   logic        take_host_word;
   logic        capture_low;
   logic        capture_high;
   logic [7:0]  tx_low;
   logic [7:0]  tx_high;

   mmc_cmd_sequencer #(.BLOCK_WORDS(BLOCK_WORDS)) seq0 (
      .clk, .reset, .bd_start, .bd_cmd, .bd_rd, .bd_wr,
      .bd_bsy, .bd_rdy, .bd_iordy, .bd_err,
      .spi_req, .spi_rsp,
      .clear_words, .step_word, .step_block, .clear_blocks,
      .last_word, .last_block, .block_byte_addr,
      .take_host_word, .capture_low, .capture_high,
      .tx_low, .tx_high
   );

   transfer_tracker #(
      .BLOCK_WORDS(BLOCK_WORDS),
      .BLOCKS_PER_REQ(BLOCKS_PER_REQ)
   ) tracker0 (
      .clk, .reset, .bd_start, .bd_addr,
      .clear_words, .step_word, .step_block, .clear_blocks,
      .last_word, .last_block, .block_byte_addr
   );

   word_staging staging0 (
      .clk, .reset, .bd_data_in,
      .take_host_word, .capture_low, .capture_high,
      .rx_byte(spi_rsp.data), .tx_low, .tx_high, .bd_data_out
   );

   spi_byte_engine #(.SLOW_DIV(SLOW_DIV), .FAST_DIV(FAST_DIV)) spi0 (
      .clk, .reset, .req(spi_req), .rsp(spi_rsp),
      .mmc_cs, .mmc_sclk, .mmc_do, .mmc_di
   );

endmodule

//--- test/mmc_card_model.sv
// Behavioral SPI-mode MMC card with a byte memory, command log and injectable command errors.
`timescale 1ns/1ps

module mmc_card_model #(
   parameter int MEM_BYTES = 1024
)
(
   input  logic        mmc_cs,
   input  logic        mmc_sclk,
   input  logic        mmc_do,
   output logic        mmc_di,
   input  logic        inject_err,
   output logic [31:0] cmd0_count,
   output logic [31:0] cmd1_count,
   output logic [31:0] cmd16_count,
   output logic [31:0] block_len
);

   logic [7:0]  mem [0:MEM_BYTES-1];
   logic [7:0]  rsp_q [$];
   logic [47:0] frame;
   logic [7:0]  in_sr;
   logic [7:0]  out_sr;
   int          bit_cnt;
   int          frame_cnt;
   int          wr_cnt;
   logic [31:0] wr_addr;
   logic        cmd1_seen;
   logic        wr_wait_token;
   logic        wr_active;

   initial
   begin
      int i;
      for (i = 0; i < MEM_BYTES; i++)
         mem[i] = 8'(i) ^ 8'(i >> 8) ^ 8'ha5;
      cmd0_count    = '0;
      cmd1_count    = '0;
      cmd16_count   = '0;
      block_len     = 32'd512;
      cmd1_seen     = 1'b0;
      in_sr         = 8'hff;
      out_sr        = 8'hff;
      bit_cnt       = 0;
      frame_cnt     = 0;
      wr_cnt        = 0;
      wr_addr       = '0;
      wr_wait_token = 1'b0;
      wr_active     = 1'b0;
   end

   task automatic run_command(input logic [47:0] f);
      logic [31:0] arg;
      int          i;
      arg = f[39:8];
      // One filler byte ahead of every R1.
      rsp_q.push_back(8'hff);
      case (f[47:40])
         8'h40:
         begin
            cmd0_count = cmd0_count + 1;
            cmd1_seen = 1'b0;
            rsp_q.push_back(8'h01);
         end
         8'h41:
         begin
            cmd1_count = cmd1_count + 1;
            // Still initializing on the first CMD1.
            rsp_q.push_back(cmd1_seen ? 8'h00 : 8'h01);
            cmd1_seen = 1'b1;
         end
         8'h50:
         begin
            cmd16_count = cmd16_count + 1;
            block_len = arg;
            rsp_q.push_back(8'h00);
         end
         8'h51:
         begin
            if (inject_err)
               rsp_q.push_back(8'h04);
            else
            begin
               rsp_q.push_back(8'h00);
               rsp_q.push_back(8'hff);
               rsp_q.push_back(8'hfe);
               for (i = 0; i < int'(block_len); i++)
                  rsp_q.push_back(mem[(int'(arg) + i) % MEM_BYTES]);
               rsp_q.push_back(8'h3c);
               rsp_q.push_back(8'hc3);
            end
         end
         8'h58:
         begin
            if (inject_err)
               rsp_q.push_back(8'h04);
            else
            begin
               rsp_q.push_back(8'h00);
               wr_addr = arg;
               wr_wait_token = 1'b1;
            end
         end
         // Illegal command.
         default:
            rsp_q.push_back(8'h04);
      endcase
   endtask

   task automatic take_byte(input logic [7:0] b);
      if (wr_active)
      begin
         if (wr_cnt < int'(block_len))
            mem[(int'(wr_addr) + wr_cnt) % MEM_BYTES] = b;
         wr_cnt++;
         // Data accepted, then busy for three bytes.
         if (wr_cnt == int'(block_len) + 2)
         begin
            wr_active = 1'b0;
            rsp_q.push_back(8'h05);
            rsp_q.push_back(8'h00);
            rsp_q.push_back(8'h00);
            rsp_q.push_back(8'h00);
         end
      end
      else if (wr_wait_token)
      begin
         if (b == 8'hfe)
         begin
            wr_wait_token = 1'b0;
            wr_active = 1'b1;
            wr_cnt = 0;
         end
      end
      else if (frame_cnt > 0 || b[7:6] == 2'b01)
      begin
         frame = {frame[39:0], b};
         frame_cnt++;
         if (frame_cnt == 6)
         begin
            frame_cnt = 0;
            run_command(frame);
         end
      end
   endtask

   // Mode 0: sample on rising SCLK, shift out after falling SCLK.
   always @(mmc_sclk or mmc_cs)
   begin
      if (mmc_cs)
      begin
         bit_cnt = 0;
         frame_cnt = 0;
         out_sr = 8'hff;
         wr_active = 1'b0;
         wr_wait_token = 1'b0;
         rsp_q.delete();
      end
      else if (mmc_sclk)
      begin
         in_sr = {in_sr[6:0], mmc_do};
         bit_cnt++;
      end
      else if (bit_cnt == 8)
      begin
         bit_cnt = 0;
         take_byte(in_sr);
         out_sr = (rsp_q.size() > 0) ? rsp_q.pop_front() : 8'hff;
      end
      else
         out_sr = {out_sr[6:0], 1'b1};
   end

   assign mmc_di = mmc_cs ? 1'b1 : out_sr[7];

endmodule

//--- test/mmc_block_dev_tb.sv
// Testbench for the MMC block device with clock, reset, trace reader, host driver and checks.
`timescale 1ns/1ps

module mmc_block_dev_tb
   import mmc_pkg::*;
();

   localparam int BLOCK_WORDS    = 8;
   localparam int BLOCKS_PER_REQ = 2;
   localparam int BLOCK_BYTES    = BLOCK_WORDS * 2;
   localparam int REQ_WORDS      = BLOCK_WORDS * BLOCKS_PER_REQ;
   localparam int MEM_BYTES      = 1024;
   localparam int REQ_LIMIT      = 60000;

   logic        clk = 1'b0;
   logic        reset;
   bd_cmd_e     bd_cmd;
   logic        bd_start;
   logic        bd_bsy;
   logic        bd_rdy;
   logic        bd_err;
   logic [23:0] bd_addr;
   logic [15:0] bd_data_in;
   logic [15:0] bd_data_out;
   logic        bd_rd;
   logic        bd_wr;
   logic        bd_iordy;
   logic        mmc_cs;
   logic        mmc_di;
   logic        mmc_do;
   logic        mmc_sclk;
   logic        inject_err;
   logic [31:0] cmd0_count;
   logic [31:0] cmd1_count;
   logic [31:0] cmd16_count;
   logic [31:0] block_len;

   logic [7:0]  shadow [0:MEM_BYTES-1];
   logic [31:0] lfsr;
   logic        card_up;
   int          errors;
   int          timeouts;

   always #50 clk = ~clk;

   mmc_block_dev #(
      .BLOCK_WORDS(BLOCK_WORDS),
      .BLOCKS_PER_REQ(BLOCKS_PER_REQ),
      .SLOW_DIV(4),
      .FAST_DIV(1)
   ) dut0 (
      .clk, .reset, .bd_cmd, .bd_start, .bd_bsy, .bd_rdy, .bd_err, .bd_addr,
      .bd_data_in, .bd_data_out, .bd_rd, .bd_wr, .bd_iordy,
      .mmc_cs, .mmc_di, .mmc_do, .mmc_sclk
   );

   mmc_card_model #(.MEM_BYTES(MEM_BYTES)) card0 (
      .mmc_cs, .mmc_sclk, .mmc_do, .mmc_di, .inject_err,
      .cmd0_count, .cmd1_count, .cmd16_count, .block_len
   );

   // Taps 32, 22, 2, 1.
   function automatic logic [31:0] lfsr_step(input logic [31:0] s);
      lfsr_step = {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
   endfunction

   task automatic next_random_word(output logic [15:0] w);
      int i;
      w = '0;
      for (i = 0; i < 16; i++)
      begin
         lfsr = lfsr_step(lfsr);
         w = {w[14:0], lfsr[0]};
      end
   endtask

   task automatic check_value(input string name, input logic [31:0] got,
                              input logic [31:0] expected);
      if (got !== expected)
      begin
         errors++;
         $display("ERR %0t %s got %0h expected %0h", $time, name, got, expected);
      end
   endtask

   task automatic run_request(input logic [1:0] op, input logic [23:0] blk,
                              input logic inj, input logic exp_err);
      int          cyc;
      int          words;
      int          err_cycles;
      logic        err_last;
      logic        bring_up;
      int          base;
      int          a;
      logic [15:0] wdata;
      logic [31:0] c0;
      logic [31:0] c1;
      logic [31:0] c16;
      base = int'(blk) * BLOCK_BYTES;
      // Reads and writes bring the card up first when it is not up yet.
      bring_up = (op == 2'd0) || (!card_up && op != 2'd3);
      c0 = cmd0_count;
      c1 = cmd1_count;
      c16 = cmd16_count;
      bd_cmd = bd_cmd_e'(op);
      bd_addr = blk;
      inject_err = inj;
      bd_start = 1'b1;
      @(negedge clk);
      bd_start = 1'b0;
      check_value("bd_bsy", 32'(bd_bsy), 32'd0);
      @(negedge clk);
      check_value("bd_bsy", 32'(bd_bsy), 32'd1);

      words = 0;
      err_cycles = 0;
      err_last = 1'b0;
      for (cyc = 0; cyc < REQ_LIMIT && bd_bsy; cyc++)
      begin
         err_last = bd_err;
         if (bd_err)
            err_cycles++;
         if (bd_cmd == BD_READ)
         begin
            if (bd_rd)
               bd_rd = 1'b0;
            else if (bd_iordy)
            begin
               if (words >= REQ_WORDS)
               begin
                  errors++;
                  $display("bd_iordy rose again after the last read word at %0t", $time);
               end
               else
               begin
                  a = base + 2 * words;
                  check_value("bd_data_out", 32'(bd_data_out),
                              32'({shadow[a + 1], shadow[a]}));
                  words++;
                  bd_rd = 1'b1;
               end
            end
         end
         else if (bd_cmd == BD_WRITE)
         begin
            if (bd_wr && bd_iordy)
               bd_wr = 1'b0;
            else if (!bd_wr && bd_rdy && !bd_iordy)
            begin
               next_random_word(wdata);
               a = base + 2 * words;
               bd_data_in = wdata;
               bd_wr = 1'b1;
               shadow[a] = wdata[7:0];
               shadow[a + 1] = wdata[15:8];
               words++;
            end
         end
         @(negedge clk);
      end

      bd_rd = 1'b0;
      bd_wr = 1'b0;
      inject_err = 1'b0;
      if (bd_bsy)
      begin
         timeouts++;
         $display("Timeout: request %0d on block %0h did not finish", op, blk);
      end
      else
      begin
         check_value("bd_err cycles", 32'(err_cycles), 32'(exp_err));
         check_value("bd_err before bd_bsy fall", 32'(err_last), 32'(exp_err));
         check_value("bd_err", 32'(bd_err), 32'd0);
         check_value("bd_iordy", 32'(bd_iordy), 32'd0);
         check_value("mmc_cs", 32'(mmc_cs), 32'd1);
         check_value("mmc_sclk", 32'(mmc_sclk), 32'd0);
         check_value("word count", 32'(words),
                     (op != 2'd0 && !exp_err) ? 32'(REQ_WORDS) : 32'd0);
         if (op == 2'd2 && !exp_err)
         begin
            for (a = base; a < base + REQ_WORDS * 2; a++)
               check_value($sformatf("card mem[%0d]", a), 32'(card0.mem[a]), 32'(shadow[a]));
         end
         if (bring_up)
         begin
            check_value("CMD0 count", cmd0_count - c0, 32'd1);
            check_value("CMD1 count", cmd1_count - c1, 32'd2);
            check_value("CMD16 count", cmd16_count - c16, 32'd1);
            check_value("CMD16 length", block_len, 32'(BLOCK_BYTES));
            card_up = 1'b1;
         end
         else
         begin
            check_value("CMD0 count", cmd0_count - c0, 32'd0);
            check_value("CMD16 count", cmd16_count - c16, 32'd0);
         end
      end
   endtask

   initial
   begin
      int               fd;
      int               n;
      int               k;
      logic [8*120-1:0] line;
      logic [31:0]      f_op;
      logic [31:0]      f_blk;
      logic [31:0]      f_inj;
      logic [31:0]      f_err;
      errors = 0;
      timeouts = 0;
      card_up = 1'b0;
      lfsr = 32'h6593abc9;
      reset = 1'b1;
      bd_cmd = BD_RESET;
      bd_start = 1'b0;
      bd_addr = '0;
      bd_data_in = '0;
      bd_rd = 1'b0;
      bd_wr = 1'b0;
      inject_err = 1'b0;
      repeat (2) @(negedge clk);
      reset = 1'b0;
      @(negedge clk);

      check_value("bd_bsy", 32'(bd_bsy), 32'd0);
      check_value("bd_err", 32'(bd_err), 32'd0);
      check_value("bd_iordy", 32'(bd_iordy), 32'd0);
      check_value("bd_rdy", 32'(bd_rdy), 32'd1);
      check_value("mmc_cs", 32'(mmc_cs), 32'd1);
      check_value("mmc_sclk", 32'(mmc_sclk), 32'd0);

      // Expected memory starts as the card's fill.
      for (k = 0; k < MEM_BYTES; k++)
         shadow[k] = card0.mem[k];

      fd = $fopen("test/mmc_trace.txt", "r");
      if (fd == 0)
      begin
         errors++;
         $display("Could not open the trace file test/mmc_trace.txt");
      end
      else
      begin
         while (timeouts == 0 && $fgets(line, fd) != 0)
         begin
            n = $sscanf(line, "%h %h %h %h", f_op, f_blk, f_inj, f_err);
            if (n == 4)
            begin
               run_request(f_op[1:0], f_blk[23:0], f_inj[0], f_err[0]);
               for (k = 0; k < 3; k++)
               begin
                  @(negedge clk);
                  check_value("bd_iordy", 32'(bd_iordy), 32'd0);
                  check_value("bd_bsy", 32'(bd_bsy), 32'd0);
               end
            end
         end
         $fclose(fd);
      end

      $display("Run finished with %0d errors and %0d timeouts", errors, timeouts);
      if (errors == 0 && timeouts == 0)
         $display("Test passed");
      else
         $display("Test failed");
      $finish;
   end

endmodule

//--- test/mmc_trace.txt
# op blk inj err: op 0 reset, 1 read, 2 write; blk is the block address in hex
# inj makes the card reject the next CMD17 or CMD24; err is the expected bd_err
1 04 0 0
0 00 0 0
2 02 0 0
1 02 0 0
1 03 0 0
2 10 0 0
1 10 0 0
2 20 1 1
1 20 0 0
2 20 0 0
1 20 0 0
1 11 1 1
1 11 0 0
0 00 0 0
2 3e 0 0
1 3e 0 0
1 04 0 0
2 03 0 0
1 02 0 0

//--- filelist.f
design/mmc_pkg.sv
design/spi_byte_engine.sv
design/mmc_cmd_sequencer.sv
design/transfer_tracker.sv
design/word_staging.sv
design/mmc_block_dev.sv
test/mmc_card_model.sv
test/mmc_block_dev_tb.sv

//--- run.sh
#!/bin/sh
# Build with Verilator and run; the exit status follows the testbench result.
cd "$(dirname "$0")" &&
verilator --binary --timing -f filelist.f --top-module mmc_block_dev_tb &&
./obj_dir/Vmmc_block_dev_tb | tee /dev/stderr | grep -qx "Test passed" &&
echo "Simulation passed" ||
{ echo "Simulation failed"; exit 1; }
